//--- source/beam_pkg.sv
// numeric formats shared by every stage of the beamformer
package beam_pkg;

    // input samples are signed 16-bit integers
    localparam int SAMPLE_WIDTH = 16;

    // weights are signed fractions with 7 fraction bits, so 8'h40 is one half
    localparam int WEIGHT_WIDTH = 8;
    localparam int WEIGHT_FRAC = 7;

    // one complex product after the shift by WEIGHT_FRAC needs 18 bits
    localparam int PRODUCT_WIDTH = 18;

    // four 18-bit products add up to at most 20 bits
    localparam int SUM_WIDTH = 20;

    localparam int LANES = 8;
    localparam int CHANNELS = 4;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    // real part sits in the upper half of every complex value
    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_sample_t;

    typedef struct packed {
        weight_t re;
        weight_t im;
    } cplx_weight_t;

    typedef struct packed {
        logic signed [PRODUCT_WIDTH-1:0] re;
        logic signed [PRODUCT_WIDTH-1:0] im;
    } cplx_product_t;

    // lane 0 sits in the low bits of each array
    typedef cplx_sample_t [LANES-1:0] lanes_t;
    typedef cplx_product_t [LANES-1:0] product_lanes_t;
    typedef cplx_weight_t [CHANNELS-1:0] weight_set_t;

endpackage

//--- source/stream_pkg.sv
// beats that travel between the stages of the beamformer
package stream_pkg;

    // one input beat of a channel, also the format of the combined output beat
    typedef struct packed {
        beam_pkg::lanes_t lanes;
        logic last;
    } in_beat_t;

    // all four weighted channels of one joined transfer
    // the last flag is the one taken from channel 0 at the join
    typedef struct packed {
        beam_pkg::product_lanes_t [beam_pkg::CHANNELS-1:0] channel;
        logic last;
    } weighted_beat_t;

endpackage

//--- source/stream_join.sv
`timescale 1ns/1ps

// joins the four channel streams so that they move as one transfer
// no channel is ever consumed alone, all of them go on the same edge
module stream_join (
    input  logic clock,
    input  logic resetn,
    input  logic [beam_pkg::CHANNELS-1:0] ch_valid,
    input  stream_pkg::in_beat_t ch_beat [beam_pkg::CHANNELS],
    output logic [beam_pkg::CHANNELS-1:0] ch_ready,
    output logic join_valid,
    output beam_pkg::lanes_t join_lanes [beam_pkg::CHANNELS],
    output logic join_last,
    input  logic join_ready
);

    // last flags of all channels gathered for the agreement check
    logic [beam_pkg::CHANNELS-1:0] last_flags;

    // the joined beat exists only once every channel offers one
    assign join_valid = &ch_valid;

    // ready goes back to every channel together, and only when the whole set is there
    // so a channel that shows up early simply waits for the others
    assign ch_ready = {beam_pkg::CHANNELS{join_valid && join_ready}};

    // channel 0 stands for the whole set
    assign join_last = ch_beat[0].last;

    always_comb begin
        for (int c = 0; c < beam_pkg::CHANNELS; c++) begin
            join_lanes[c] = ch_beat[c].lanes;
            last_flags[c] = ch_beat[c].last;
        end
    end

    // the sources must frame their packets alike, otherwise channel 0's last
    // would cut the other channels in the wrong place
    last_flags_agree: assert property (
        @(posedge clock) disable iff (!resetn)
        (join_valid && join_ready) |-> (&last_flags || !(|last_flags))
    ) else $error("channel last flags differ on a joined transfer");

endmodule

//--- source/complex_weigher.sv
`timescale 1ns/1ps

// applies one channel's complex weight to all eight lanes of a beat
// purely combinational, the result is captured by the first register stage
module complex_weigher (
    input  beam_pkg::lanes_t lanes,
    input  beam_pkg::cplx_weight_t weight,
    output beam_pkg::product_lanes_t products
);

    always_comb begin
        // every operand is widened to the full product width first, so the
        // multiplies and the add run at that width with no overflow
        logic signed [beam_pkg::SAMPLE_WIDTH+beam_pkg::WEIGHT_WIDTH:0] xr;
        logic signed [beam_pkg::SAMPLE_WIDTH+beam_pkg::WEIGHT_WIDTH:0] xi;
        logic signed [beam_pkg::SAMPLE_WIDTH+beam_pkg::WEIGHT_WIDTH:0] wr;
        logic signed [beam_pkg::SAMPLE_WIDTH+beam_pkg::WEIGHT_WIDTH:0] wi;
        logic signed [beam_pkg::SAMPLE_WIDTH+beam_pkg::WEIGHT_WIDTH:0] acc_re;
        logic signed [beam_pkg::SAMPLE_WIDTH+beam_pkg::WEIGHT_WIDTH:0] acc_im;

        // the weight is the same for all lanes
        wr = {{(beam_pkg::SAMPLE_WIDTH + 1){weight.re[beam_pkg::WEIGHT_WIDTH-1]}}, weight.re};
        wi = {{(beam_pkg::SAMPLE_WIDTH + 1){weight.im[beam_pkg::WEIGHT_WIDTH-1]}}, weight.im};

        for (int l = 0; l < beam_pkg::LANES; l++) begin
            xr = {{(beam_pkg::WEIGHT_WIDTH + 1){lanes[l].re[beam_pkg::SAMPLE_WIDTH-1]}},
                  lanes[l].re};
            xi = {{(beam_pkg::WEIGHT_WIDTH + 1){lanes[l].im[beam_pkg::SAMPLE_WIDTH-1]}},
                  lanes[l].im};

            // (xr + j xi)(wr + j wi)
            // each partial product fits in 24 bits, so the 25-bit sum is exact
            acc_re = xr * wr - xi * wi;
            acc_im = xr * wi + xi * wr;

            // dropping the low WEIGHT_FRAC bits of a two's complement value is the
            // arithmetic shift, it rounds toward minus infinity
            // the remaining 18 bits hold the full range of the shifted result
            products[l].re = acc_re[beam_pkg::WEIGHT_FRAC +: beam_pkg::PRODUCT_WIDTH];
            products[l].im = acc_im[beam_pkg::WEIGHT_FRAC +: beam_pkg::PRODUCT_WIDTH];
        end
    end

endmodule

//--- source/channel_combiner.sv
`timescale 1ns/1ps

// adds the weighted channels lane by lane and clamps each sum to a 16-bit sample
module channel_combiner (
    input  stream_pkg::weighted_beat_t weighted,
    output stream_pkg::in_beat_t combined
);

    // sign extension of one product to the width of the channel sum
    function automatic logic signed [beam_pkg::SUM_WIDTH-1:0] widen(
        input logic signed [beam_pkg::PRODUCT_WIDTH-1:0] value
    );
        widen = {{(beam_pkg::SUM_WIDTH - beam_pkg::PRODUCT_WIDTH)
                  {value[beam_pkg::PRODUCT_WIDTH-1]}}, value};
    endfunction

    // the sum fits in 16 bits when every bit above the sample's sign bit
    // repeats that sign bit, otherwise the sign of the sum picks the bound
    function automatic beam_pkg::sample_t saturate(
        input logic signed [beam_pkg::SUM_WIDTH-1:0] value
    );
        logic [beam_pkg::SUM_WIDTH-beam_pkg::SAMPLE_WIDTH:0] top;

        top = value[beam_pkg::SUM_WIDTH-1:beam_pkg::SAMPLE_WIDTH-1];
        if (&top || !(|top)) begin
            saturate = value[beam_pkg::SAMPLE_WIDTH-1:0];
        end else if (value[beam_pkg::SUM_WIDTH-1]) begin
            saturate = {1'b1, {(beam_pkg::SAMPLE_WIDTH - 1){1'b0}}};
        end else begin
            saturate = {1'b0, {(beam_pkg::SAMPLE_WIDTH - 1){1'b1}}};
        end
    endfunction

    always_comb begin
        logic signed [beam_pkg::SUM_WIDTH-1:0] sum_re;
        logic signed [beam_pkg::SUM_WIDTH-1:0] sum_im;

        for (int l = 0; l < beam_pkg::LANES; l++) begin
            sum_re = '0;
            sum_im = '0;
            // real and imaginary parts are summed and clamped on their own
            for (int c = 0; c < beam_pkg::CHANNELS; c++) begin
                sum_re = sum_re + widen(weighted.channel[c][l].re);
                sum_im = sum_im + widen(weighted.channel[c][l].im);
            end
            combined.lanes[l].re = saturate(sum_re);
            combined.lanes[l].im = saturate(sum_im);
        end
        combined.last = weighted.last;
    end

endmodule

//--- source/pipe_register.sv
`timescale 1ns/1ps

// one-entry register stage with valid/ready on both sides
// takes a new beat while empty or while its own beat leaves on the same edge,
// which keeps the stream at one beat per cycle
module pipe_register #(
    parameter type payload_t = logic
) (
    input  logic clock,
    input  logic resetn,
    input  logic in_valid,
    input  payload_t in_payload,
    output logic in_ready,
    output logic out_valid,
    output payload_t out_payload,
    input  logic out_ready
);

    // ready upstream does not look at in_valid, so no loop forms
    // through the join in front of this stage
    assign in_ready = !out_valid || out_ready;

    // the stage is full whenever out_valid is high
    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // the payload only moves on an accepted beat and keeps its value otherwise
    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            out_payload <= in_payload;
        end
    end

    // a stalled beat must stay offered and unchanged until it is taken
    stall_holds_beat: assert property (
        @(posedge clock) disable iff (!resetn)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_payload))
    ) else $error("pipe register dropped or changed a stalled beat");

endmodule

//--- source/beamformer_top.sv
`timescale 1ns/1ps

// four-channel complex beamformer
// join, weight every channel, register, sum and clamp, register again
// with out_ready held high a beat leaves two edges after it was accepted
module beamformer_top (
    input  logic clock,
    input  logic resetn,
    input  logic [beam_pkg::CHANNELS-1:0] ch_valid,
    input  stream_pkg::in_beat_t ch_beat [beam_pkg::CHANNELS],
    output logic [beam_pkg::CHANNELS-1:0] ch_ready,
    input  beam_pkg::weight_set_t weights,
    output logic out_valid,
    output stream_pkg::in_beat_t out_beat,
    input  logic out_ready
);

    // joined transfer in front of the first register
    logic join_valid;
    logic join_ready;
    logic join_last;
    beam_pkg::lanes_t join_lanes [beam_pkg::CHANNELS];

    // weighted channels, filled by the weighers and the joined last flag
    stream_pkg::weighted_beat_t weighed_beat;

    // between the first register, the combiner and the second register
    logic weighted_valid;
    logic weighted_ready;
    stream_pkg::weighted_beat_t weighted_beat;
    stream_pkg::in_beat_t combined_beat;

    stream_join u_join (
        .clock      (clock),
        .resetn     (resetn),
        .ch_valid   (ch_valid),
        .ch_beat    (ch_beat),
        .ch_ready   (ch_ready),
        .join_valid (join_valid),
        .join_lanes (join_lanes),
        .join_last  (join_last),
        .join_ready (join_ready)
    );

    // the weights are sampled together with the beat at the accepting edge
    for (genvar c = 0; c < beam_pkg::CHANNELS; c++) begin : g_weigher
        complex_weigher u_weigher (
            .lanes    (join_lanes[c]),
            .weight   (weights[c]),
            .products (weighed_beat.channel[c])
        );
    end

    assign weighed_beat.last = join_last;

    pipe_register #(
        .payload_t (stream_pkg::weighted_beat_t)
    ) u_weighted_stage (
        .clock       (clock),
        .resetn      (resetn),
        .in_valid    (join_valid),
        .in_payload  (weighed_beat),
        .in_ready    (join_ready),
        .out_valid   (weighted_valid),
        .out_payload (weighted_beat),
        .out_ready   (weighted_ready)
    );

    channel_combiner u_combiner (
        .weighted (weighted_beat),
        .combined (combined_beat)
    );

    // second stage drives the output stream directly
    pipe_register #(
        .payload_t (stream_pkg::in_beat_t)
    ) u_output_stage (
        .clock       (clock),
        .resetn      (resetn),
        .in_valid    (weighted_valid),
        .in_payload  (combined_beat),
        .in_ready    (weighted_ready),
        .out_valid   (out_valid),
        .out_payload (out_beat),
        .out_ready   (out_ready)
    );

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

// free running clock with a 4 ns period and a reset held low for 10 cycles
module tb_clock (
    output logic clock,
    output logic resetn
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // reset is released on a falling edge, well away from the sampling edge
    initial begin
        resetn = 1'b0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;
    end

endmodule

//--- testbench/beamformer_tb.sv
`timescale 1ns/1ps

// testbench for the four-channel beamformer
// inputs change on the falling edge and the handshakes are looked at 1 ns later,
// so everything sampled is settled before the next rising edge
module beamformer_tb;

    logic clock;
    logic resetn;
    logic [beam_pkg::CHANNELS-1:0] ch_valid;
    stream_pkg::in_beat_t ch_beat [beam_pkg::CHANNELS];
    logic [beam_pkg::CHANNELS-1:0] ch_ready;
    beam_pkg::weight_set_t weights;
    logic out_valid;
    stream_pkg::in_beat_t out_beat;
    logic out_ready;

    // expected output beats in the order in which the join took them
    stream_pkg::in_beat_t expected_q [$];

    logic [31:0] lcg_state = 32'h4369;

    tb_clock clock_gen (
        .clock  (clock),
        .resetn (resetn)
    );

    beamformer_top dut (
        .clock     (clock),
        .resetn    (resetn),
        .ch_valid  (ch_valid),
        .ch_beat   (ch_beat),
        .ch_ready  (ch_ready),
        .weights   (weights),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    // the low bits of an LCG repeat quickly, so the halves are swapped
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    task automatic fail_run();
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %b actual %b", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_beat(input string name, input stream_pkg::in_beat_t expected,
                              input stream_pkg::in_beat_t actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    // clamp to the signed 16-bit sample range
    function automatic beam_pkg::sample_t clamp_sample(input int value);
        if (value > 32767) begin
            return 16'sh7fff;
        end
        if (value < -32768) begin
            return 16'sh8000;
        end
        return beam_pkg::sample_t'(value);
    endfunction

    // complex multiply per channel, shift down by the 7 fraction bits,
    // add the four channels in plain integers and clamp at the end
    function automatic stream_pkg::in_beat_t model_beat(
        input beam_pkg::weight_set_t w,
        input stream_pkg::in_beat_t beats [beam_pkg::CHANNELS]
    );
        stream_pkg::in_beat_t result;
        int sum_re;
        int sum_im;
        int xr;
        int xi;
        int wr;
        int wi;

        for (int l = 0; l < beam_pkg::LANES; l++) begin
            sum_re = 0;
            sum_im = 0;
            for (int c = 0; c < beam_pkg::CHANNELS; c++) begin
                xr = int'(beats[c].lanes[l].re);
                xi = int'(beats[c].lanes[l].im);
                wr = int'(w[c].re);
                wi = int'(w[c].im);
                sum_re += (xr * wr - xi * wi) >>> beam_pkg::WEIGHT_FRAC;
                sum_im += (xr * wi + xi * wr) >>> beam_pkg::WEIGHT_FRAC;
            end
            result.lanes[l].re = clamp_sample(sum_re);
            result.lanes[l].im = clamp_sample(sum_im);
        end
        result.last = beats[0].last;
        return result;
    endfunction

    // extreme beats use full scale samples of one sign on every lane
    task automatic load_beat(input int c, input logic last, input bit extreme, input logic neg);
        logic [31:0] r;

        for (int l = 0; l < beam_pkg::LANES; l++) begin
            r = lcg_next();
            if (extreme) begin
                ch_beat[c].lanes[l].re = neg ? 16'sh8000 : 16'sh7fff;
                ch_beat[c].lanes[l].im = neg ? 16'sh8000 : 16'sh7fff;
            end else begin
                ch_beat[c].lanes[l].re = r[15:0];
                ch_beat[c].lanes[l].im = r[31:16];
            end
        end
        ch_beat[c].last = last;
        ch_valid[c] = 1'b1;
    endtask

    // weights may change every cycle, only their value at the accepting edge counts
    // in extreme mode all channels share one sign so that the four sums pile up
    task automatic drive_weights(input bit extreme);
        logic [31:0] r;
        logic neg;

        r = lcg_next();
        neg = r[0];
        for (int c = 0; c < beam_pkg::CHANNELS; c++) begin
            r = lcg_next();
            if (extreme) begin
                weights[c].re = neg ? 8'sh80 : 8'sh7f;
                weights[c].im = 8'sh00;
            end else begin
                weights[c].re = r[7:0];
                weights[c].im = r[15:8];
            end
        end
    endtask

    // pushes count beats through the DUT and checks every output beat against the model
    // skew_max delays each channel's valid on its own, stall_pct drops out_ready at random
    task automatic run_beats(input string name, input int count, input int skew_max,
                             input int stall_pct, input bit extreme);
        int delay [beam_pkg::CHANNELS];
        int accepted;
        int cycles;
        bit taken;
        logic [1:0] accept_hist;
        logic beat_last;
        logic beat_neg;
        logic [31:0] r;

        accepted = 0;
        cycles = 0;
        taken = 1'b0;
        accept_hist = '0;
        r = lcg_next();
        beat_last = r[0];
        beat_neg = r[1];
        for (int c = 0; c < beam_pkg::CHANNELS; c++) begin
            delay[c] = 0;
        end

        while (accepted < count || expected_q.size() != 0) begin
            if (cycles > count * 50 + 100) begin
                $display("%s: timed out with %0d beats still missing at the output",
                         name, expected_q.size() + count - accepted);
                fail_run();
            end

            // every channel gave up its beat on the last edge, the next set is drawn here
            if (taken) begin
                ch_valid = '0;
                r = lcg_next();
                beat_last = r[0];
                beat_neg = r[1];
                for (int c = 0; c < beam_pkg::CHANNELS; c++) begin
                    r = lcg_next();
                    delay[c] = int'(r % (skew_max + 1));
                end
            end
            for (int c = 0; c < beam_pkg::CHANNELS; c++) begin
                if (!ch_valid[c] && accepted < count) begin
                    if (delay[c] > 0) begin
                        delay[c]--;
                    end else begin
                        load_beat(c, beat_last, extreme, beat_neg);
                    end
                end
            end
            drive_weights(extreme);
            r = lcg_next();
            out_ready = (stall_pct == 0) || ((r % 100) >= stall_pct);

            #1;
            // no channel may be taken before the whole set is there
            // a complete set waits only while both stages hold a beat and the output stalls
            for (int c = 0; c < beam_pkg::CHANNELS; c++) begin
                check_flag({name, " ch_ready"},
                           (&ch_valid) && (expected_q.size() < 2 || out_ready),
                           ch_ready[c]);
            end
            taken = (&ch_valid) && (&ch_ready);
            if (taken) begin
                expected_q.push_back(model_beat(weights, ch_beat));
                accepted++;
            end

            // with out_ready held high a beat leaves two edges after its accepting edge
            if (stall_pct == 0) begin
                check_flag({name, " out_valid latency"}, accept_hist[1], out_valid);
            end
            accept_hist = {accept_hist[0], taken};

            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    $display("%s: an output beat appeared that no input transfer produced",
                             name);
                    fail_run();
                end
                check_beat(name, expected_q.pop_front(), out_beat);
            end

            @(negedge clock);
            cycles++;
        end
    endtask

    initial begin
        int wait_cycles;

        ch_valid = '0;
        for (int c = 0; c < beam_pkg::CHANNELS; c++) begin
            ch_beat[c] = '0;
        end
        weights = '0;
        out_ready = 1'b0;

        wait_cycles = 0;
        while (resetn !== 1'b1) begin
            if (wait_cycles > 50) begin
                $display("reset was never released");
                fail_run();
            end
            @(posedge clock);
            wait_cycles++;
        end
        @(negedge clock);

        // both stages start empty and nothing is offered, so nothing may move
        out_ready = 1'b1;
        for (int i = 0; i < 3; i++) begin
            #1;
            check_flag("reset out_valid", 1'b0, out_valid);
            for (int c = 0; c < beam_pkg::CHANNELS; c++) begin
                check_flag("reset ch_ready", 1'b0, ch_ready[c]);
            end
            @(negedge clock);
        end

        run_beats("weighted sum", 200, 0, 0, 1'b0);
        run_beats("channel skew", 100, 6, 0, 1'b0);
        run_beats("back-pressure", 200, 2, 40, 1'b0);
        run_beats("saturation", 50, 0, 0, 1'b1);
        run_beats("last flag", 80, 3, 25, 1'b0);

        $display("Regression passed");
        $finish;
    end

endmodule

//--- filelist.f
source/beam_pkg.sv
source/stream_pkg.sv
source/stream_join.sv
source/complex_weigher.sv
source/channel_combiner.sv
source/pipe_register.sv
source/beamformer_top.sv
testbench/tb_clock.sv
testbench/beamformer_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the beamformer testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module beamformer_tb -f filelist.f \
    --Mdir obj_dir -o beamformer_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/beamformer_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
echo "pass line not found in the simulation output"
exit 1
